// File: verilog/pinmux_pkg.sv
// Shared widths, word map and bus/struct types for the pin-mux register block
// Word indexes 15 to 31 are unmapped and read as zero
`default_nettype none

package pinmux_pkg;

   //----------------------------------------------------------------------
   // Bus widths
   //----------------------------------------------------------------------
   localparam int REG_DATA_W = 32;
   localparam int REG_ADDR_W = 8;    // Byte address
   localparam int REG_BE_W   = 4;
   localparam int WORD_IDX_W = 5;    // addr[6:2]

   //----------------------------------------------------------------------
   // Word map
   //----------------------------------------------------------------------
   localparam logic [WORD_IDX_W-1:0] ADDR_CHIP_ID       = 5'd0;
   localparam logic [WORD_IDX_W-1:0] ADDR_FUSE_ID       = 5'd1;
   localparam logic [WORD_IDX_W-1:0] ADDR_GLBL_CFG1     = 5'd2;
   localparam logic [WORD_IDX_W-1:0] ADDR_GLBL_CFG2     = 5'd3;
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_IN       = 5'd4;   // Read only
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_OUT      = 5'd5;
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_DIR      = 5'd6;
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_TYPE     = 5'd7;
   localparam logic [WORD_IDX_W-1:0] ADDR_INTR          = 5'd8;
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_INT_STAT = 5'd9;   // W1C
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_INT_SET  = 5'd10;  // W1S
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_INT_MASK = 5'd11;
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_POS_SEL  = 5'd12;
   localparam logic [WORD_IDX_W-1:0] ADDR_GPIO_NEG_SEL  = 5'd13;
   localparam logic [WORD_IDX_W-1:0] ADDR_MULTI_FUNC    = 5'd14;

   // Chip ID fields, read back as 8268_1301
   localparam logic [15:0] MANU_ID    = 16'h8268;  // "RD"
   localparam logic [3:0]  TOTAL_CORE = 4'h1;
   localparam logic [3:0]  CHIP_ID    = 4'h3;
   localparam logic [7:0]  CHIP_REV   = 8'h01;

   //----------------------------------------------------------------------
   // Bus and block-level structs
   //----------------------------------------------------------------------
   typedef struct packed {
      logic                  cs;
      logic                  wr;
      logic [REG_ADDR_W-1:0] addr;
      logic [REG_DATA_W-1:0] wdata;
      logic [REG_BE_W-1:0]   be;
   } reg_req_t;

   // Write as seen by the register blocks, idx valid every cycle
   typedef struct packed {
      logic                  stb;     // One-shot, writes only
      logic [WORD_IDX_W-1:0] idx;
      logic [REG_DATA_W-1:0] wdata;
      logic [REG_BE_W-1:0]   be;
   } reg_wr_t;

   // All active low, 0 holds the peripheral in reset
   typedef struct packed {
      logic [1:0] cpu_core_rst_n;
      logic       cpu_intf_rst_n;
      logic       qspim_rst_n;
      logic       sspim_rst_n;
      logic       uart_rst_n;
      logic       i2cm_rst_n;
      logic       usb_rst_n;
   } periph_rst_t;

   typedef struct packed {
      logic [31:0] fuse_mhartid;
      logic [9:0]  cfg_pulse_1us;
      logic [1:0]  cfg_riscv_debug_sel;
   } riscv_cfg_t;

   typedef struct packed {
      logic [15:0] irq_lines;
      logic        soft_irq;
      logic [2:0]  user_irq;
   } irq_out_t;

   typedef struct packed {
      logic [31:0] out_data;
      logic [31:0] dir_sel;          // Pad direction
      logic [31:0] out_type;         // 0 static, 1 waveform
      logic [31:0] posedge_int_sel;
      logic [31:0] negedge_int_sel;
      logic [31:0] multi_func_sel;
   } gpio_cfg_t;

endpackage

`default_nettype wire

// File: verilog/byte_en_reg.sv
// 32-bit register, loads only the enabled bytes while en is high
`timescale 1ns/1ps
`default_nettype none

module byte_en_reg #(
   parameter logic [31:0] RESET_VAL = 32'h0
) (
   input  logic        mclk,
   input  logic        h_reset_n,
   input  logic        en,          // Word selected by a write strobe
   input  logic [3:0]  be,
   input  logic [31:0] wdata,
   output logic [31:0] q
);

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         q <= RESET_VAL;
      end
      else if (en)
      begin
         // Unselected bytes hold
         for (int b = 0; b < 4; b++)
         begin
            if (be[b])
               q[8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/reg_bus_ctrl.sv
// Register bus slave, every access acks one cycle after cs is seen
// Host must hold the request until ack and drop cs within a cycle after it
`timescale 1ns/1ps
`default_nettype none

module reg_bus_ctrl (
   input  logic                 mclk,
   input  logic                 h_reset_n,
   input  pinmux_pkg::reg_req_t req,
   input  logic [31:0]          glbl_rdata,
   input  logic [31:0]          gpio_rdata,
   input  logic [31:0]          int_rdata,
   output pinmux_pkg::reg_wr_t  wr,
   output logic [31:0]          reg_rdata,
   output logic                 reg_ack
);

   logic        acc_start;   // cs seen, ack not yet given
   logic [31:0] rdata_mux;

   assign acc_start = req.cs && !reg_ack;
   assign rdata_mux = glbl_rdata | gpio_rdata | int_rdata;  // Unselected blocks give 0

   // Broadcast to all register blocks
   assign wr.stb   = acc_start && req.wr;   // Same cycle ack is registered
   assign wr.idx   = req.addr[6:2];
   assign wr.wdata = req.wdata;
   assign wr.be    = req.be;

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         reg_ack <= 1'b0;
      else
         reg_ack <= acc_start;   // Single-cycle pulse
   end

   // Read word captured together with the ack
   always_ff @(posedge mclk)
   begin
      if (acc_start)
         reg_rdata <= rdata_mux;
   end

   // Host sees exactly one ack per access
   a_ack_one_shot : assert property (
      @(posedge mclk) disable iff (!h_reset_n) reg_ack |=> !reg_ack);

endmodule

`default_nettype wire

// File: verilog/glbl_cfg_regs.sv
// Chip ID, fuse hart ID, the two global config words and the interrupt word
// Peripheral resets come out of reset asserted until software sets them
`timescale 1ns/1ps
`default_nettype none

module glbl_cfg_regs #(
   parameter logic [31:0] FUSE_RESET = 32'hA55A_A55A
) (
   input  logic                    mclk,
   input  logic                    h_reset_n,
   input  pinmux_pkg::reg_wr_t     wr,
   input  logic [1:0]              ext_intr_in,
   input  logic                    usb_intr,
   input  logic                    i2cm_intr,
   input  logic                    gpio_intr,    // Summary from GPIO status
   output logic [31:0]             rdata,
   output pinmux_pkg::periph_rst_t periph_rst,
   output pinmux_pkg::riscv_cfg_t  riscv_cfg,
   output pinmux_pkg::irq_out_t    irq
);

   logic [31:0] chip_id_word;
   logic [31:0] fuse_q;
   logic [31:0] cfg1_q;
   logic [31:0] cfg2_q;
   logic [31:0] intr_word;
   logic [10:0] irq_sw_lo;   // irq_lines[10:0]
   logic [3:0]  irq_sw_hi;   // soft_irq and user_irq
   logic        intr_wen;

   assign chip_id_word = {pinmux_pkg::MANU_ID, pinmux_pkg::TOTAL_CORE,
                          pinmux_pkg::CHIP_ID, pinmux_pkg::CHIP_REV};

   //----------------------------------------------------------------------
   // Fuse ID and global config words
   //----------------------------------------------------------------------
   byte_en_reg #(.RESET_VAL(FUSE_RESET)) u_fuse_reg (
      .mclk (mclk), .h_reset_n (h_reset_n),
      .en   (wr.stb && (wr.idx == pinmux_pkg::ADDR_FUSE_ID)),
      .be   (wr.be), .wdata (wr.wdata), .q (fuse_q));

   byte_en_reg #(.RESET_VAL(32'h0)) u_cfg1_reg (
      .mclk (mclk), .h_reset_n (h_reset_n),
      .en   (wr.stb && (wr.idx == pinmux_pkg::ADDR_GLBL_CFG1)),
      .be   (wr.be), .wdata (wr.wdata), .q (cfg1_q));

   byte_en_reg #(.RESET_VAL(32'h0)) u_cfg2_reg (
      .mclk (mclk), .h_reset_n (h_reset_n),
      .en   (wr.stb && (wr.idx == pinmux_pkg::ADDR_GLBL_CFG2)),
      .be   (wr.be), .wdata (wr.wdata), .q (cfg2_q));

   // Reset controls, low holds the peripheral in reset
   assign periph_rst.cpu_intf_rst_n = cfg1_q[0];
   assign periph_rst.qspim_rst_n    = cfg1_q[1];
   assign periph_rst.sspim_rst_n    = cfg1_q[2];
   assign periph_rst.uart_rst_n     = cfg1_q[3];
   assign periph_rst.i2cm_rst_n     = cfg1_q[4];
   assign periph_rst.usb_rst_n      = cfg1_q[5];
   assign periph_rst.cpu_core_rst_n = cfg1_q[9:8];   // One per core

   assign riscv_cfg.fuse_mhartid        = fuse_q;
   assign riscv_cfg.cfg_pulse_1us       = cfg2_q[9:0];
   assign riscv_cfg.cfg_riscv_debug_sel = cfg2_q[31:30];

   //----------------------------------------------------------------------
   // Interrupt word, software bits around the live inputs
   //----------------------------------------------------------------------
   assign intr_wen = wr.stb && (wr.idx == pinmux_pkg::ADDR_INTR);

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         irq_sw_lo <= '0;
         irq_sw_hi <= '0;
      end
      else if (intr_wen)
      begin
         if (wr.be[0])
            irq_sw_lo[7:0] <= wr.wdata[7:0];
         if (wr.be[1])
            irq_sw_lo[10:8] <= wr.wdata[10:8];   // 15:11 are live
         if (wr.be[2])
            irq_sw_hi <= wr.wdata[19:16];
      end
   end

   assign intr_word = {12'h0, irq_sw_hi,
                       gpio_intr, ext_intr_in, usb_intr, i2cm_intr,  // Bits 15..11
                       irq_sw_lo};

   assign irq.irq_lines = intr_word[15:0];
   assign irq.soft_irq  = intr_word[16];
   assign irq.user_irq  = intr_word[19:17];

   always_comb
   begin
      case (wr.idx)
         pinmux_pkg::ADDR_CHIP_ID   : rdata = chip_id_word;
         pinmux_pkg::ADDR_FUSE_ID   : rdata = fuse_q;
         pinmux_pkg::ADDR_GLBL_CFG1 : rdata = cfg1_q;
         pinmux_pkg::ADDR_GLBL_CFG2 : rdata = cfg2_q;
         pinmux_pkg::ADDR_INTR      : rdata = intr_word;
         default                    : rdata = 32'h0;   // Not ours
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/gpio_port_regs.sv
// GPIO input synchronizer and capture, plus the six GPIO config words
// SYNC_STAGES must be at least 1, input read lags the pins by SYNC_STAGES+1
`timescale 1ns/1ps
`default_nettype none

module gpio_port_regs #(
   parameter int SYNC_STAGES = 2
) (
   input  logic                  mclk,
   input  logic                  h_reset_n,
   input  pinmux_pkg::reg_wr_t   wr,
   input  logic [31:0]           gpio_in_data,      // Async pad inputs
   output logic [31:0]           rdata,
   output pinmux_pkg::gpio_cfg_t gpio_cfg,
   output logic [31:0]           cfg_gpio_data_in,  // Captured input word
   output logic [31:0]           gpio_prev_indata   // Synchronizer output
);

   logic [SYNC_STAGES-1:0][31:0] sync_q;
   logic [5:0][31:0]             cfg_q;
   logic [5:0]                   cfg_wen;

   //----------------------------------------------------------------------
   // Input path
   //----------------------------------------------------------------------
   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
      begin
         sync_q           <= '0;
         cfg_gpio_data_in <= '0;
      end
      else
      begin
         sync_q[0] <= gpio_in_data;
         for (int s = 1; s < SYNC_STAGES; s++)
            sync_q[s] <= sync_q[s-1];
         cfg_gpio_data_in <= sync_q[SYNC_STAGES-1];   // One cycle behind sync
      end
   end

   assign gpio_prev_indata = sync_q[SYNC_STAGES-1];

   //----------------------------------------------------------------------
   // Config words, order matches gpio_cfg_t
   //----------------------------------------------------------------------
   assign cfg_wen[0] = wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_OUT);
   assign cfg_wen[1] = wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_DIR);
   assign cfg_wen[2] = wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_TYPE);
   assign cfg_wen[3] = wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_POS_SEL);
   assign cfg_wen[4] = wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_NEG_SEL);
   assign cfg_wen[5] = wr.stb && (wr.idx == pinmux_pkg::ADDR_MULTI_FUNC);

   for (genvar i = 0; i < 6; i++)
   begin : g_cfg
      byte_en_reg #(.RESET_VAL(32'h0)) u_cfg_reg (
         .mclk      (mclk),
         .h_reset_n (h_reset_n),
         .en        (cfg_wen[i]),
         .be        (wr.be),
         .wdata     (wr.wdata),
         .q         (cfg_q[i])
      );
   end

   assign gpio_cfg.out_data        = cfg_q[0];
   assign gpio_cfg.dir_sel         = cfg_q[1];
   assign gpio_cfg.out_type        = cfg_q[2];
   assign gpio_cfg.posedge_int_sel = cfg_q[3];
   assign gpio_cfg.negedge_int_sel = cfg_q[4];
   assign gpio_cfg.multi_func_sel  = cfg_q[5];

   always_comb
   begin
      case (wr.idx)
         pinmux_pkg::ADDR_GPIO_IN      : rdata = cfg_gpio_data_in;
         pinmux_pkg::ADDR_GPIO_OUT     : rdata = cfg_q[0];
         pinmux_pkg::ADDR_GPIO_DIR     : rdata = cfg_q[1];
         pinmux_pkg::ADDR_GPIO_TYPE    : rdata = cfg_q[2];
         pinmux_pkg::ADDR_GPIO_POS_SEL : rdata = cfg_q[3];
         pinmux_pkg::ADDR_GPIO_NEG_SEL : rdata = cfg_q[4];
         pinmux_pkg::ADDR_MULTI_FUNC   : rdata = cfg_q[5];
         default                       : rdata = 32'h0;
      endcase
   end

endmodule

`default_nettype wire

// File: verilog/gpio_int_ctrl.sv
// GPIO interrupt status with W1C, W1S and mask, plus the summary interrupt
// A pending event always beats a software clear in the same cycle
`timescale 1ns/1ps
`default_nettype none

module gpio_int_ctrl (
   input  logic                mclk,
   input  logic                h_reset_n,
   input  pinmux_pkg::reg_wr_t wr,
   input  logic [31:0]         gpio_int_event,   // One-cycle event per pin
   output logic [31:0]         rdata,
   output logic                gpio_intr
);

   logic [31:0] int_stat;
   logic [31:0] stat_nxt;
   logic [31:0] int_mask;
   logic        clr_hit;
   logic        set_hit;

   assign clr_hit = wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_INT_STAT);
   assign set_hit = wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_INT_SET);

   //----------------------------------------------------------------------
   // Status update, byte by byte
   //----------------------------------------------------------------------
   always_comb
   begin
      for (int b = 0; b < 4; b++)
      begin
         if (clr_hit && wr.be[b])
            stat_nxt[8*b +: 8] = int_stat[8*b +: 8] & ~wr.wdata[8*b +: 8];
         else if (set_hit && wr.be[b])
            stat_nxt[8*b +: 8] = int_stat[8*b +: 8] | wr.wdata[8*b +: 8];
         else
            stat_nxt[8*b +: 8] = int_stat[8*b +: 8];
      end
      stat_nxt = stat_nxt | gpio_int_event;   // Events win
   end

   always_ff @(posedge mclk or negedge h_reset_n)
   begin
      if (!h_reset_n)
         int_stat <= '0;
      else
         int_stat <= stat_nxt;
   end

   byte_en_reg #(.RESET_VAL(32'h0)) u_mask_reg (
      .mclk      (mclk),
      .h_reset_n (h_reset_n),
      .en        (wr.stb && (wr.idx == pinmux_pkg::ADDR_GPIO_INT_MASK)),
      .be        (wr.be),
      .wdata     (wr.wdata),
      .q         (int_mask)
   );

   assign gpio_intr = |(int_stat & int_mask);   // To interrupt word bit 15

   always_comb
   begin
      case (wr.idx)
         pinmux_pkg::ADDR_GPIO_INT_STAT,
         pinmux_pkg::ADDR_GPIO_INT_SET  : rdata = int_stat;   // Both read status
         pinmux_pkg::ADDR_GPIO_INT_MASK : rdata = int_mask;
         default                        : rdata = 32'h0;
      endcase
   end

   // No clear may drop an event in flight
   a_event_sets_stat : assert property (
      @(posedge mclk) disable iff (!h_reset_n)
      (gpio_int_event != '0) |=>
         ((int_stat & $past(gpio_int_event)) == $past(gpio_int_event)));

endmodule

`default_nettype wire

// File: verilog/pinmux_reg.sv
// Global and pin-mux register block top, bus pins to the three register blocks
// Word indexes 15 to 31 read as zero and ignore writes
`timescale 1ns/1ps
`default_nettype none

module pinmux_reg #(
   parameter logic [31:0] FUSE_RESET  = 32'hA55A_A55A,
   parameter int          SYNC_STAGES = 2
) (
   input  logic                                mclk,
   input  logic                                h_reset_n,

   // Register bus
   input  logic                                reg_cs,
   input  logic                                reg_wr,
   input  logic [pinmux_pkg::REG_ADDR_W-1:0]   reg_addr,
   input  logic [pinmux_pkg::REG_DATA_W-1:0]   reg_wdata,
   input  logic [pinmux_pkg::REG_BE_W-1:0]     reg_be,
   output logic [pinmux_pkg::REG_DATA_W-1:0]   reg_rdata,
   output logic                                reg_ack,

   // Interrupt sources
   input  logic [1:0]                          ext_intr_in,
   input  logic                                usb_intr,
   input  logic                                i2cm_intr,

   // GPIO pins
   input  logic [31:0]                         gpio_in_data,
   input  logic [31:0]                         gpio_int_event,

   output pinmux_pkg::periph_rst_t             periph_rst,
   output pinmux_pkg::riscv_cfg_t              riscv_cfg,
   output pinmux_pkg::irq_out_t                irq,
   output pinmux_pkg::gpio_cfg_t               gpio_cfg,
   output logic [31:0]                         cfg_gpio_data_in,
   output logic [31:0]                         gpio_prev_indata
);

   pinmux_pkg::reg_req_t bus_req;
   pinmux_pkg::reg_wr_t  blk_wr;      // Shared by all blocks
   logic [31:0]          glbl_rdata;
   logic [31:0]          gpio_rdata;
   logic [31:0]          int_rdata;
   logic                 gpio_intr;

   assign bus_req = '{cs: reg_cs, wr: reg_wr, addr: reg_addr,
                      wdata: reg_wdata, be: reg_be};

   reg_bus_ctrl u_bus_ctrl (
      .mclk       (mclk),
      .h_reset_n  (h_reset_n),
      .req        (bus_req),
      .glbl_rdata (glbl_rdata),
      .gpio_rdata (gpio_rdata),
      .int_rdata  (int_rdata),
      .wr         (blk_wr),
      .reg_rdata  (reg_rdata),
      .reg_ack    (reg_ack)
   );

   glbl_cfg_regs #(.FUSE_RESET(FUSE_RESET)) u_glbl_cfg (
      .mclk        (mclk),
      .h_reset_n   (h_reset_n),
      .wr          (blk_wr),
      .ext_intr_in (ext_intr_in),
      .usb_intr    (usb_intr),
      .i2cm_intr   (i2cm_intr),
      .gpio_intr   (gpio_intr),
      .rdata       (glbl_rdata),
      .periph_rst  (periph_rst),
      .riscv_cfg   (riscv_cfg),
      .irq         (irq)
   );

   gpio_port_regs #(.SYNC_STAGES(SYNC_STAGES)) u_gpio_port (
      .mclk             (mclk),
      .h_reset_n        (h_reset_n),
      .wr               (blk_wr),
      .gpio_in_data     (gpio_in_data),
      .rdata            (gpio_rdata),
      .gpio_cfg         (gpio_cfg),
      .cfg_gpio_data_in (cfg_gpio_data_in),
      .gpio_prev_indata (gpio_prev_indata)
   );

   gpio_int_ctrl u_gpio_int (
      .mclk           (mclk),
      .h_reset_n      (h_reset_n),
      .wr             (blk_wr),
      .gpio_int_event (gpio_int_event),
      .rdata          (int_rdata),
      .gpio_intr      (gpio_intr)
   );

endmodule

`default_nettype wire

// File: testbench/tb_pinmux_model.svh
// Register map model and typed compare tasks, included inside the testbench top
// Expects report_fail to be declared before the include
`ifndef TB_PINMUX_MODEL_SVH
`define TB_PINMUX_MODEL_SVH

logic [31:0] mdl_word [0:31];   // Stored words by word index
logic [31:0] mdl_stat;          // GPIO interrupt status
logic [31:0] mdl_gpio_in;       // Settled GPIO input word
logic [3:0]  mdl_live;          // ext_intr_in[1:0], usb, i2cm

task automatic model_reset();
   for (int i = 0; i < 32; i++)
      mdl_word[i] = 32'h0;
   mdl_word[1] = 32'hA55A_A55A;   // Fuse hart ID default
   mdl_stat    = 32'h0;
   mdl_gpio_in = 32'h0;
   mdl_live    = 4'h0;
endtask

function automatic void model_write(input logic [4:0] idx, input logic [31:0] wdata,
                                    input logic [3:0] be);
   logic [31:0] bmask;
   for (int b = 0; b < 4; b++)
      bmask[8*b +: 8] = {8{be[b]}};
   case (idx)
      pinmux_pkg::ADDR_FUSE_ID, pinmux_pkg::ADDR_GLBL_CFG1, pinmux_pkg::ADDR_GLBL_CFG2,
      pinmux_pkg::ADDR_GPIO_OUT, pinmux_pkg::ADDR_GPIO_DIR, pinmux_pkg::ADDR_GPIO_TYPE,
      pinmux_pkg::ADDR_GPIO_INT_MASK, pinmux_pkg::ADDR_GPIO_POS_SEL,
      pinmux_pkg::ADDR_GPIO_NEG_SEL, pinmux_pkg::ADDR_MULTI_FUNC :
         mdl_word[idx] = (mdl_word[idx] & ~bmask) | (wdata & bmask);
      pinmux_pkg::ADDR_INTR :   // Only 19:16 and 10:0 are stored
         mdl_word[idx] = (mdl_word[idx] & ~(bmask & 32'h000F_07FF)) |
                         (wdata & bmask & 32'h000F_07FF);
      pinmux_pkg::ADDR_GPIO_INT_STAT : mdl_stat = mdl_stat & ~(wdata & bmask);  // W1C
      pinmux_pkg::ADDR_GPIO_INT_SET  : mdl_stat = mdl_stat | (wdata & bmask);   // W1S
      default : ;   // Chip ID, GPIO in, unmapped
   endcase
endfunction

function automatic logic [31:0] model_intr();
   logic gpio_sum;
   gpio_sum = |(mdl_stat & mdl_word[11]);
   return {12'h0, mdl_word[8][19:16], gpio_sum, mdl_live, mdl_word[8][10:0]};
endfunction

function automatic logic [31:0] model_read(input logic [4:0] idx);
   case (idx)
      pinmux_pkg::ADDR_CHIP_ID : return 32'h8268_1301;
      pinmux_pkg::ADDR_GPIO_IN : return mdl_gpio_in;
      pinmux_pkg::ADDR_INTR    : return model_intr();
      pinmux_pkg::ADDR_GPIO_INT_STAT, pinmux_pkg::ADDR_GPIO_INT_SET : return mdl_stat;
      default : return (idx <= 5'd14) ? mdl_word[idx] : 32'h0;   // 15..31 unmapped
   endcase
endfunction

function automatic pinmux_pkg::periph_rst_t exp_rst();
   pinmux_pkg::periph_rst_t r;
   r.cpu_core_rst_n = mdl_word[2][9:8];
   r.cpu_intf_rst_n = mdl_word[2][0];
   r.qspim_rst_n    = mdl_word[2][1];
   r.sspim_rst_n    = mdl_word[2][2];
   r.uart_rst_n     = mdl_word[2][3];
   r.i2cm_rst_n     = mdl_word[2][4];
   r.usb_rst_n      = mdl_word[2][5];
   return r;
endfunction

function automatic pinmux_pkg::riscv_cfg_t exp_riscv();
   return {mdl_word[1], mdl_word[3][9:0], mdl_word[3][31:30]};
endfunction

function automatic pinmux_pkg::irq_out_t exp_irq();
   logic [31:0] w;
   w = model_intr();
   return {w[15:0], w[16], w[19:17]};   // lines, soft, user
endfunction

function automatic pinmux_pkg::gpio_cfg_t exp_gpio_cfg();
   return {mdl_word[5], mdl_word[6], mdl_word[7], mdl_word[12], mdl_word[13], mdl_word[14]};
endfunction

//----------------------------------------------------------------------
// Typed compares
//----------------------------------------------------------------------
task automatic check_data(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp)
      report_fail($sformatf("MISMATCH %s got %h exp %h", name, got, exp));
endtask

task automatic check_rst(input pinmux_pkg::periph_rst_t got, input pinmux_pkg::periph_rst_t exp);
   if (got !== exp)
      report_fail($sformatf("MISMATCH periph_rst got %h exp %h", got, exp));
endtask

task automatic check_riscv(input pinmux_pkg::riscv_cfg_t got, input pinmux_pkg::riscv_cfg_t exp);
   if (got !== exp)
      report_fail($sformatf("MISMATCH riscv_cfg got %h exp %h", got, exp));
endtask

task automatic check_irq(input pinmux_pkg::irq_out_t got, input pinmux_pkg::irq_out_t exp);
   if (got !== exp)
      report_fail($sformatf("MISMATCH irq got %h exp %h", got, exp));
endtask

task automatic check_gpio_cfg(input pinmux_pkg::gpio_cfg_t got,
                              input pinmux_pkg::gpio_cfg_t exp);
   if (got !== exp)
      report_fail($sformatf("MISMATCH gpio_cfg got %h exp %h", got, exp));
endtask

`endif

// File: testbench/tb_pinmux_reg.sv
// Random register traffic against a map model, fixed seed
// Inputs change on the falling edge, outputs are sampled there too
`timescale 1ns/1ps
`default_nettype none

module tb_pinmux_reg;

   localparam int ACK_TIMEOUT = 20;   // Cycles to wait for reg_ack

   logic        mclk;
   logic        h_reset_n;
   logic        reg_cs;
   logic        reg_wr;
   logic [7:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic [3:0]  reg_be;
   logic [31:0] reg_rdata;
   logic        reg_ack;
   logic [1:0]  ext_intr_in;
   logic        usb_intr;
   logic        i2cm_intr;
   logic [31:0] gpio_in_data;
   logic [31:0] gpio_int_event;
   logic [31:0] cfg_gpio_data_in;
   logic [31:0] gpio_prev_indata;
   pinmux_pkg::periph_rst_t periph_rst;
   pinmux_pkg::riscv_cfg_t  riscv_cfg;
   pinmux_pkg::irq_out_t    irq;
   pinmux_pkg::gpio_cfg_t   gpio_cfg;

   int          seed_ret;
   logic [31:0] rnd;
   logic [31:0] wd;
   logic [31:0] evt;
   logic [31:0] got;

   pinmux_reg dut0 (
      .mclk (mclk), .h_reset_n (h_reset_n),
      .reg_cs (reg_cs), .reg_wr (reg_wr), .reg_addr (reg_addr), .reg_wdata (reg_wdata),
      .reg_be (reg_be), .reg_rdata (reg_rdata), .reg_ack (reg_ack),
      .ext_intr_in (ext_intr_in), .usb_intr (usb_intr), .i2cm_intr (i2cm_intr),
      .gpio_in_data (gpio_in_data), .gpio_int_event (gpio_int_event),
      .periph_rst (periph_rst), .riscv_cfg (riscv_cfg), .irq (irq), .gpio_cfg (gpio_cfg),
      .cfg_gpio_data_in (cfg_gpio_data_in), .gpio_prev_indata (gpio_prev_indata));

   always #4 mclk = ~mclk;   // 8 ns period

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

`include "tb_pinmux_model.svh"

   //----------------------------------------------------------------------
   // Bus access, entered and left on a falling edge
   //----------------------------------------------------------------------
   task automatic bus_access(input logic wr_en, input logic [4:0] idx, input logic [31:0] wdata,
                             input logic [3:0] be, input logic [31:0] ev,
                             output logic [31:0] rdata);
      int wait_cnt;
      reg_cs         = 1'b1;
      reg_wr         = wr_en;
      reg_addr       = {1'b0, idx, 2'b00};
      reg_wdata      = wdata;
      reg_be         = be;
      gpio_int_event = ev;     // Lands on the strobe edge
      @(negedge mclk);
      gpio_int_event = 32'h0;  // One cycle only
      wait_cnt = 0;
      while (!reg_ack && wait_cnt < ACK_TIMEOUT)
      begin
         @(negedge mclk);
         wait_cnt++;
      end
      if (!reg_ack)
         report_fail("reg_ack never came, bus access timed out");
      rdata  = reg_rdata;
      reg_cs = 1'b0;
      reg_wr = 1'b0;
      if (wr_en)
         model_write(idx, wdata, be);
      mdl_stat = mdl_stat | ev;   // Event wins over clear
      @(negedge mclk);            // Idle edge, next access starts with ack low
   endtask

   task automatic write_reg(input logic [4:0] idx, input logic [31:0] wdata,
                            input logic [3:0] be, input logic [31:0] ev);
      logic [31:0] unused_rd;
      bus_access(1'b1, idx, wdata, be, ev, unused_rd);
   endtask

   task automatic read_check(input logic [4:0] idx, output logic [31:0] rdata);
      bus_access(1'b0, idx, 32'h0, 4'h0, 32'h0, rdata);
      check_data($sformatf("reg_rdata[word %0d]", idx), rdata, model_read(idx));
   endtask

   task automatic pulse_event(input logic [31:0] ev);
      gpio_int_event = ev;
      @(negedge mclk);
      gpio_int_event = 32'h0;
      mdl_stat = mdl_stat | ev;
   endtask

   task automatic check_outputs();
      @(negedge mclk);   // Let the last edge settle
      check_rst(periph_rst, exp_rst());
      check_riscv(riscv_cfg, exp_riscv());
      check_irq(irq, exp_irq());
      check_gpio_cfg(gpio_cfg, exp_gpio_cfg());
   endtask

   initial
   begin
      mclk           = 1'b0;
      h_reset_n      = 1'b0;
      reg_cs         = 1'b0;
      reg_wr         = 1'b0;
      reg_addr       = 8'h0;
      reg_wdata      = 32'h0;
      reg_be         = 4'h0;
      ext_intr_in    = 2'b00;
      usb_intr       = 1'b0;
      i2cm_intr      = 1'b0;
      gpio_in_data   = 32'h0;
      gpio_int_event = 32'h0;
      seed_ret       = $urandom(32'hc2520d9b);
      model_reset();
      repeat (5) @(posedge mclk);
      @(negedge mclk);
      h_reset_n = 1'b1;
      @(negedge mclk);

      // Reset values on outputs and all 32 words
      check_outputs();
      for (int i = 0; i < 32; i++)
         read_check(i[4:0], got);

      // Random writes with byte enables, any word index
      for (int n = 0; n < 200; n++)
      begin
         rnd = $urandom;
         wd  = $urandom;
         write_reg(rnd[4:0], wd, rnd[11:8], 32'h0);
         read_check(rnd[4:0], got);
         check_outputs();
      end

      // GPIO input path, held 4 cycles
      for (int n = 0; n < 10; n++)
      begin
         rnd          = $urandom;
         gpio_in_data = rnd;
         repeat (4) @(negedge mclk);
         mdl_gpio_in = rnd;
         check_data("cfg_gpio_data_in", cfg_gpio_data_in, rnd);
         check_data("gpio_prev_indata", gpio_prev_indata, rnd);
         read_check(pinmux_pkg::ADDR_GPIO_IN, got);
      end

      //----------------------------------------------------------------------
      // GPIO interrupt status: events, clears, sets, mask
      //----------------------------------------------------------------------
      for (int n = 0; n < 150; n++)
      begin
         rnd = $urandom;
         evt = $urandom & $urandom;   // Sparse events
         wd  = $urandom;
         case (rnd[1:0])
            2'd0 : pulse_event(evt);
            2'd1 :
            begin
               write_reg(pinmux_pkg::ADDR_GPIO_INT_STAT, wd | evt, rnd[7:4], evt);
               read_check(pinmux_pkg::ADDR_GPIO_INT_STAT, got);
               check_data("int_stat event bits", got & evt, evt);   // Clear lost
            end
            2'd2 : write_reg(pinmux_pkg::ADDR_GPIO_INT_SET, wd, rnd[7:4], evt);
            default : write_reg(pinmux_pkg::ADDR_GPIO_INT_MASK, wd, rnd[7:4], 32'h0);
         endcase
         read_check(pinmux_pkg::ADDR_GPIO_INT_STAT, got);
         read_check(pinmux_pkg::ADDR_GPIO_INT_SET, got);
         check_outputs();   // irq_lines[15] is the masked summary
      end

      // Live interrupt inputs
      for (int n = 0; n < 40; n++)
      begin
         rnd         = $urandom;
         ext_intr_in = rnd[3:2];
         usb_intr    = rnd[1];
         i2cm_intr   = rnd[0];
         mdl_live    = rnd[3:0];
         read_check(pinmux_pkg::ADDR_INTR, got);
         check_data("intr rdata[31:20]", got & 32'hFFF0_0000, 32'h0);
         check_outputs();
      end

      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+testbench
verilog/pinmux_pkg.sv
verilog/byte_en_reg.sv
verilog/reg_bus_ctrl.sv
verilog/glbl_cfg_regs.sv
verilog/gpio_port_regs.sv
verilog/gpio_int_ctrl.sv
verilog/pinmux_reg.sv
testbench/tb_pinmux_reg.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f filelist.f --top-module tb_pinmux_reg -o tb_pinmux_reg
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_pinmux_reg 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
